// File: rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    parameter int DATA_W     = 16;  // Register and ALU width
    parameter int REG_ADDR_W = 3;   // Eight registers

    typedef logic [DATA_W-1:0]     data_t;      // Operand or result
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // Register number

    // Operations carried down the pipe
    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_and  = 3'd2,
        op_or   = 3'd3,
        op_xor  = 3'd4,
        op_slt  = 3'd5,  // Signed less-than, 1 or 0
        op_addi = 3'd6,  // Source 1 plus immediate
        op_li   = 3'd7   // Immediate only
    } alu_op_t;

    // Source of an EX operand
    typedef enum logic [1:0] {
        fwd_none = 2'b00,  // Value read into ID/EX
        fwd_wb   = 2'b01,  // From MEM/WB
        fwd_mem  = 2'b10   // From EX/MEM
    } fwd_sel_t;

endpackage

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter int DATA_W     = pipe_pkg::DATA_W,
    parameter int REG_ADDR_W = pipe_pkg::REG_ADDR_W
) (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire pipe_pkg::reg_addr_t rd_addr1,  // Read port 1
    input  wire pipe_pkg::reg_addr_t rd_addr2,  // Read port 2
    input  wire                      wr_en,
    input  wire pipe_pkg::reg_addr_t wr_addr,
    input  wire pipe_pkg::data_t     wr_data,
    output pipe_pkg::data_t          rd_data1,
    output pipe_pkg::data_t          rd_data2
);
    import pipe_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [DATA_W-1:0] regs [NUM_REGS];  // Register 0 is never written

    // Write bypass so that a reader three behind the writer sees the new value
    function automatic data_t read_port(
        input reg_addr_t addr,
        input data_t     stored,  // Current contents of addr
        input logic      we,
        input reg_addr_t waddr,
        input data_t     wdata
    );
        if (addr == '0)
            read_port = '0;  // Hardwired zero
        else if (we && (addr == waddr))
            read_port = wdata;
        else
            read_port = stored;
    endfunction

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wr_en && (wr_addr != '0))
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data1 = read_port(rd_addr1, regs[rd_addr1], wr_en, wr_addr, wr_data);
    assign rd_data2 = read_port(rd_addr2, regs[rd_addr2], wr_en, wr_addr, wr_data);

endmodule

`default_nettype wire

// File: rtl/forwarding_control.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_control #(
    parameter int REG_ADDR_W = pipe_pkg::REG_ADDR_W
) (
    input  wire pipe_pkg::reg_addr_t idex_src1,       // EX operand 1 register
    input  wire pipe_pkg::reg_addr_t idex_src2,       // EX operand 2 register
    input  wire                      exmem_regwrite,  // MEM step writes
    input  wire pipe_pkg::reg_addr_t exmem_dest,
    input  wire                      memwb_regwrite,  // WB step writes
    input  wire pipe_pkg::reg_addr_t memwb_dest,
    output pipe_pkg::fwd_sel_t       fwd_src1,        // Mux select, operand 1
    output pipe_pkg::fwd_sel_t       fwd_src2         // Mux select, operand 2
);
    import pipe_pkg::*;

    localparam reg_addr_t ZERO_REG = {REG_ADDR_W{1'b0}};

    // One source at a time, the other select is left alone
    function automatic fwd_sel_t pick_source(
        input reg_addr_t src,
        input logic      mem_we,
        input reg_addr_t mem_dest,
        input logic      wb_we,
        input reg_addr_t wb_dest
    );
        logic mem_hit;
        logic wb_hit;
        mem_hit = mem_we && (mem_dest != ZERO_REG) && (mem_dest == src);
        wb_hit  = wb_we && (wb_dest != ZERO_REG) && (wb_dest == src);
        if (mem_hit)
            pick_source = fwd_mem;   // Newest result wins
        else if (wb_hit)
            pick_source = fwd_wb;
        else
            pick_source = fwd_none;  // Value from the file is current
    endfunction

    always_comb
    begin
        fwd_src1 = pick_source(idex_src1, exmem_regwrite, exmem_dest,
                               memwb_regwrite, memwb_dest);
        fwd_src2 = pick_source(idex_src2, exmem_regwrite, exmem_dest,
                               memwb_regwrite, memwb_dest);
    end

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu #(
    parameter int DATA_W = pipe_pkg::DATA_W
) (
    input  wire pipe_pkg::alu_op_t op,
    input  wire pipe_pkg::data_t   a,    // Source 1 after bypass
    input  wire pipe_pkg::data_t   b,    // Source 2 after bypass
    input  wire pipe_pkg::data_t   imm,
    output pipe_pkg::data_t        result
);
    import pipe_pkg::*;

    logic less;  // Signed a < b

    assign less = $signed(a) < $signed(b);

    always_comb
    begin
        case (op)
            op_add:  result = a + b;  // Wraps at DATA_W
            op_sub:  result = a - b;
            op_and:  result = a & b;
            op_or:   result = a | b;
            op_xor:  result = a ^ b;
            op_slt:  result = {{(DATA_W-1){1'b0}}, less};
            op_addi: result = a + imm;
            op_li:   result = imm;   // Load immediate, sources ignored
            default:
            begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/operand_read.sv
`timescale 1ns/1ps
`default_nettype none

module operand_read #(
    parameter int REG_ADDR_W = pipe_pkg::REG_ADDR_W
) (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      in_valid,     // One instruction per high cycle
    input  wire pipe_pkg::alu_op_t   in_op,
    input  wire pipe_pkg::reg_addr_t in_dest,
    input  wire pipe_pkg::reg_addr_t in_src1,
    input  wire pipe_pkg::reg_addr_t in_src2,
    input  wire pipe_pkg::data_t     in_imm,
    input  wire                      in_regwrite,
    input  wire pipe_pkg::data_t     rd_data1,     // From register file
    input  wire pipe_pkg::data_t     rd_data2,
    output pipe_pkg::reg_addr_t      rd_addr1,
    output pipe_pkg::reg_addr_t      rd_addr2,
    output logic                     idex_valid,
    output pipe_pkg::alu_op_t        idex_op,
    output pipe_pkg::reg_addr_t      idex_dest,
    output logic                     idex_regwrite,
    output pipe_pkg::reg_addr_t      idex_src1,
    output pipe_pkg::reg_addr_t      idex_src2,
    output pipe_pkg::data_t          idex_imm,
    output pipe_pkg::data_t          idex_val1,
    output pipe_pkg::data_t          idex_val2
);

    // Source numbers go straight to the file
    assign rd_addr1 = in_src1;
    assign rd_addr2 = in_src2;

    // ID/EX control
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            idex_valid    <= 1'b0;
            idex_regwrite <= 1'b0;
        end
        else
        begin
            idex_valid    <= in_valid;
            idex_regwrite <= in_valid && in_regwrite;  // Bubble never writes
        end
    end

    // ID/EX payload
    always_ff @(posedge clk)
    begin
        idex_op   <= in_op;
        idex_dest <= in_valid ? in_dest : {REG_ADDR_W{1'b0}};  // Bubble targets r0
        idex_src1 <= in_src1;
        idex_src2 <= in_src2;
        idex_imm  <= in_imm;
        idex_val1 <= rd_data1;
        idex_val2 <= rd_data2;
    end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage #(
    parameter int DATA_W = pipe_pkg::DATA_W
) (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      idex_valid,
    input  wire pipe_pkg::alu_op_t   idex_op,
    input  wire pipe_pkg::reg_addr_t idex_dest,
    input  wire                      idex_regwrite,
    input  wire pipe_pkg::data_t     idex_imm,
    input  wire pipe_pkg::data_t     idex_val1,
    input  wire pipe_pkg::data_t     idex_val2,
    input  wire pipe_pkg::fwd_sel_t  fwd_src1,
    input  wire pipe_pkg::fwd_sel_t  fwd_src2,
    output logic                     exmem_regwrite,
    output pipe_pkg::reg_addr_t      exmem_dest,
    output pipe_pkg::data_t          exmem_result,
    output logic                     memwb_valid,
    output logic                     memwb_regwrite,
    output pipe_pkg::reg_addr_t      memwb_dest,
    output pipe_pkg::data_t          memwb_result
);
    import pipe_pkg::*;

    logic  exmem_valid;  // Occupancy of the MEM step
    data_t opnd1;        // Operands after bypass
    data_t opnd2;
    data_t alu_result;

    // Same three-way mux for both operands
    function automatic data_t bypass(
        input fwd_sel_t sel,
        input data_t    idex_val,
        input data_t    mem_val,
        input data_t    wb_val
    );
        case (sel)
            fwd_mem: bypass = mem_val;
            fwd_wb:  bypass = wb_val;
            default: bypass = idex_val;
        endcase
    endfunction

    assign opnd1 = bypass(fwd_src1, idex_val1, exmem_result, memwb_result);
    assign opnd2 = bypass(fwd_src2, idex_val2, exmem_result, memwb_result);

    alu #(
        .DATA_W (DATA_W)
    ) alu_inst (
        .op     (idex_op),
        .a      (opnd1),
        .b      (opnd2),
        .imm    (idex_imm),
        .result (alu_result)
    );

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            exmem_valid    <= 1'b0;
            exmem_regwrite <= 1'b0;
            memwb_valid    <= 1'b0;
            memwb_regwrite <= 1'b0;
        end
        else
        begin
            exmem_valid    <= idex_valid;
            exmem_regwrite <= idex_regwrite;
            memwb_valid    <= exmem_valid;     // Moved unchanged as there is no data memory
            memwb_regwrite <= exmem_regwrite;
        end
    end

    always_ff @(posedge clk)
    begin
        exmem_dest   <= idex_dest;
        exmem_result <= alu_result;
        memwb_dest   <= exmem_dest;
        memwb_result <= exmem_result;
    end

endmodule

`default_nettype wire

// File: rtl/pipe_core.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_core #(
    parameter int DATA_W     = pipe_pkg::DATA_W,
    parameter int REG_ADDR_W = pipe_pkg::REG_ADDR_W
) (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      in_valid,
    input  wire pipe_pkg::alu_op_t   in_op,
    input  wire pipe_pkg::reg_addr_t in_dest,
    input  wire pipe_pkg::reg_addr_t in_src1,
    input  wire pipe_pkg::reg_addr_t in_src2,
    input  wire pipe_pkg::data_t     in_imm,
    input  wire                      in_regwrite,
    output wire                      wb_valid,     // MEM/WB seen from outside
    output wire                      wb_regwrite,
    output wire pipe_pkg::reg_addr_t wb_dest,
    output wire pipe_pkg::data_t     wb_data
);
    import pipe_pkg::*;

    wire reg_addr_t rd_addr1;
    wire reg_addr_t rd_addr2;
    wire data_t     rd_data1;
    wire data_t     rd_data2;
    wire            idex_valid;
    wire alu_op_t   idex_op;
    wire reg_addr_t idex_dest;
    wire            idex_regwrite;
    wire reg_addr_t idex_src1;
    wire reg_addr_t idex_src2;
    wire data_t     idex_imm;
    wire data_t     idex_val1;
    wire data_t     idex_val2;
    wire fwd_sel_t  fwd_src1;
    wire fwd_sel_t  fwd_src2;
    wire            exmem_regwrite;
    wire reg_addr_t exmem_dest;
    wire data_t     exmem_result;

    // MEM/WB feeds the file write port, wb_* are the same nets
    reg_file #(
        .DATA_W     (DATA_W),
        .REG_ADDR_W (REG_ADDR_W)
    ) reg_file_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .wr_en    (wb_regwrite),
        .wr_addr  (wb_dest),
        .wr_data  (wb_data),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    operand_read #(
        .REG_ADDR_W (REG_ADDR_W)
    ) operand_read_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .in_op         (in_op),
        .in_dest       (in_dest),
        .in_src1       (in_src1),
        .in_src2       (in_src2),
        .in_imm        (in_imm),
        .in_regwrite   (in_regwrite),
        .rd_data1      (rd_data1),
        .rd_data2      (rd_data2),
        .rd_addr1      (rd_addr1),
        .rd_addr2      (rd_addr2),
        .idex_valid    (idex_valid),
        .idex_op       (idex_op),
        .idex_dest     (idex_dest),
        .idex_regwrite (idex_regwrite),
        .idex_src1     (idex_src1),
        .idex_src2     (idex_src2),
        .idex_imm      (idex_imm),
        .idex_val1     (idex_val1),
        .idex_val2     (idex_val2)
    );

    forwarding_control #(
        .REG_ADDR_W (REG_ADDR_W)
    ) forwarding_control_inst (
        .idex_src1      (idex_src1),
        .idex_src2      (idex_src2),
        .exmem_regwrite (exmem_regwrite),
        .exmem_dest     (exmem_dest),
        .memwb_regwrite (wb_regwrite),
        .memwb_dest     (wb_dest),
        .fwd_src1       (fwd_src1),
        .fwd_src2       (fwd_src2)
    );

    execute_stage #(
        .DATA_W (DATA_W)
    ) execute_stage_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .idex_valid     (idex_valid),
        .idex_op        (idex_op),
        .idex_dest      (idex_dest),
        .idex_regwrite  (idex_regwrite),
        .idex_imm       (idex_imm),
        .idex_val1      (idex_val1),
        .idex_val2      (idex_val2),
        .fwd_src1       (fwd_src1),
        .fwd_src2       (fwd_src2),
        .exmem_regwrite (exmem_regwrite),
        .exmem_dest     (exmem_dest),
        .exmem_result   (exmem_result),
        .memwb_valid    (wb_valid),
        .memwb_regwrite (wb_regwrite),
        .memwb_dest     (wb_dest),
        .memwb_result   (wb_data)
    );

endmodule

`default_nettype wire

// File: testbench/pipe_fwd_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_fwd_checker #(
    parameter int DATA_W     = pipe_pkg::DATA_W,
    parameter int REG_ADDR_W = pipe_pkg::REG_ADDR_W
) (
    input  wire                      clk,
    input  wire                      wb_valid,      // DUT write-back port
    input  wire                      wb_regwrite,
    input  wire pipe_pkg::reg_addr_t wb_dest,
    input  wire pipe_pkg::data_t     wb_data,
    input  wire                      exp_push,      // Driver issued a line this cycle
    input  wire [31:0]               exp_line,      // Its line number in the file
    input  wire                      exp_regwrite,
    input  wire pipe_pkg::reg_addr_t exp_dest,
    input  wire pipe_pkg::data_t     exp_data,
    input  wire                      run_done,      // Stimulus over, look for leftovers
    output int                       pending,
    output int                       check_count,
    output int                       error_count
);
    import pipe_pkg::*;

    // Instructions in flight, oldest first
    int                    line_q[$];
    logic                  regwrite_q[$];
    logic [REG_ADDR_W-1:0] dest_q[$];
    logic [DATA_W-1:0]     data_q[$];
    int                    due_q[$];    // Falling edge where the result must show

    int                    fall_count = 0;
    int                    cur_line;
    int                    cur_due;
    logic                  cur_regwrite;
    logic [REG_ADDR_W-1:0] cur_dest;
    logic [DATA_W-1:0]     cur_data;
    bit                    leftovers_done = 1'b0;

    initial
    begin
        pending     = 0;
        check_count = 0;
        error_count = 0;
    end

    // Outputs sampled half a cycle after the edge that moved them
    always @(negedge clk)
    begin
        fall_count = fall_count + 1;
        if (exp_push === 1'b1)
        begin
            line_q.push_back(exp_line);
            regwrite_q.push_back(exp_regwrite);
            dest_q.push_back(exp_dest);
            data_q.push_back(exp_data);
            // Sampled at the next rise, leaves MEM/WB two rises later
            due_q.push_back(fall_count + 3);
        end
        if (wb_valid === 1'b1)
        begin
            if (line_q.size() == 0)
            begin
                $display("Write-back seen at %0t with no instruction in flight", $time);
                error_count = error_count + 1;
            end
            else
            begin
                cur_line     = line_q.pop_front();
                cur_regwrite = regwrite_q.pop_front();
                cur_dest     = dest_q.pop_front();
                cur_data     = data_q.pop_front();
                cur_due      = due_q.pop_front();
                check_count  = check_count + 1;
                if (fall_count != cur_due)
                begin
                    $display("** Error line %0d: write-back cycle expected %0d, actual %0d",
                             cur_line, cur_due, fall_count);
                    error_count = error_count + 1;
                end
                if (wb_dest !== cur_dest)
                begin
                    $display("** Error line %0d: wb_dest expected %0d, actual %0d",
                             cur_line, cur_dest, wb_dest);
                    error_count = error_count + 1;
                end
                if (wb_regwrite !== cur_regwrite)
                begin
                    $display("** Error line %0d: wb_regwrite expected %b, actual %b",
                             cur_line, cur_regwrite, wb_regwrite);
                    error_count = error_count + 1;
                end
                if (wb_data !== cur_data)
                begin
                    $display("** Error line %0d: wb_data expected %h, actual %h",
                             cur_line, cur_data, wb_data);
                    error_count = error_count + 1;
                end
            end
        end
        if ((run_done === 1'b1) && !leftovers_done)
        begin
            leftovers_done = 1'b1;
            if (line_q.size() != 0)
            begin
                $display("%0d issued instructions never reached write-back, oldest from line %0d",
                         line_q.size(), line_q[0]);
                error_count = error_count + 1;
            end
        end
        pending = line_q.size();
    end

endmodule

`default_nettype wire

// File: testbench/pipe_fwd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_fwd_tb;
    import pipe_pkg::*;

    localparam STIM_FILE = "testbench/pipe_fwd_stimulus.txt";
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_CYCLES = 6;  // Pipe depth plus slack

    logic      clk;
    logic      arst_n;
    logic      in_valid;
    alu_op_t   in_op;
    reg_addr_t in_dest;
    reg_addr_t in_src1;
    reg_addr_t in_src2;
    data_t     in_imm;
    logic      in_regwrite;
    wire       wb_valid;
    wire       wb_regwrite;
    reg_addr_t wb_dest;
    data_t     wb_data;

    // Expected results handed to the checker
    logic        exp_push;
    logic [31:0] exp_line;
    logic        exp_regwrite;
    reg_addr_t   exp_dest;
    data_t       exp_data;
    logic        run_done;
    int          pending;
    int          check_count;
    int          error_count;

    // Stimulus table, one entry per data line of the file
    int          line_q[$];
    logic        issue_q[$];
    logic [2:0]  op_q[$];
    reg_addr_t   dest_q[$];
    reg_addr_t   src1_q[$];
    reg_addr_t   src2_q[$];
    data_t       imm_q[$];
    logic        regwrite_q[$];
    data_t       expect_q[$];

    int          cycle_count   = 0;
    int          timeout_limit = 0;  // Zero until the file is loaded
    int          drain;
    bit          file_ok;

    pipe_core #(
        .DATA_W     (DATA_W),
        .REG_ADDR_W (REG_ADDR_W)
    ) pipe_core_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_dest     (in_dest),
        .in_src1     (in_src1),
        .in_src2     (in_src2),
        .in_imm      (in_imm),
        .in_regwrite (in_regwrite),
        .wb_valid    (wb_valid),
        .wb_regwrite (wb_regwrite),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data)
    );

    pipe_fwd_checker #(
        .DATA_W     (DATA_W),
        .REG_ADDR_W (REG_ADDR_W)
    ) pipe_fwd_checker_inst (
        .clk          (clk),
        .wb_valid     (wb_valid),
        .wb_regwrite  (wb_regwrite),
        .wb_dest      (wb_dest),
        .wb_data      (wb_data),
        .exp_push     (exp_push),
        .exp_line     (exp_line),
        .exp_regwrite (exp_regwrite),
        .exp_dest     (exp_dest),
        .exp_data     (exp_data),
        .run_done     (run_done),
        .pending      (pending),
        .check_count  (check_count),
        .error_count  (error_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // Reads every data line, comment lines fail the scan and are skipped
    task automatic load_stimulus(output bit ok);
        int               fd;
        int               got;
        int               fields;
        int               file_line;
        logic [8*160-1:0] text;
        logic             f_issue;
        logic [2:0]       f_op;
        reg_addr_t        f_dest;
        reg_addr_t        f_src1;
        reg_addr_t        f_src2;
        data_t            f_imm;
        logic             f_regwrite;
        data_t            f_exp;
        file_line = 0;
        fd = $fopen(STIM_FILE, "r");
        ok = (fd != 0);
        if (ok)
        begin
            text = '0;
            got  = $fgets(text, fd);
            while (got != 0)
            begin
                file_line = file_line + 1;
                fields = $sscanf(text, "%h %h %h %h %h %h %h %h", f_issue, f_op, f_dest,
                                 f_src1, f_src2, f_imm, f_regwrite, f_exp);
                if (fields == 8)
                begin
                    line_q.push_back(file_line);
                    issue_q.push_back(f_issue);
                    op_q.push_back(f_op);
                    dest_q.push_back(f_dest);
                    src1_q.push_back(f_src1);
                    src2_q.push_back(f_src2);
                    imm_q.push_back(f_imm);
                    regwrite_q.push_back(f_regwrite);
                    expect_q.push_back(f_exp);
                end
                text = '0;
                got  = $fgets(text, fd);
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_line(input int idx);
        in_valid     <= issue_q[idx];  // Idle lines still drive their other fields
        in_op        <= alu_op_t'(op_q[idx]);
        in_dest      <= dest_q[idx];
        in_src1      <= src1_q[idx];
        in_src2      <= src2_q[idx];
        in_imm       <= imm_q[idx];
        in_regwrite  <= regwrite_q[idx];
        exp_push     <= issue_q[idx];
        exp_line     <= line_q[idx];
        exp_regwrite <= regwrite_q[idx];
        exp_dest     <= dest_q[idx];
        exp_data     <= expect_q[idx];
    endtask

    task automatic drive_idle();
        in_valid <= 1'b0;
        exp_push <= 1'b0;
    endtask

    // Run limit from the file length
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if ((timeout_limit > 0) && (cycle_count >= timeout_limit))
        begin
            $display("Timeout after %0d cycles with %0d results outstanding",
                     cycle_count, pending);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial
    begin
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        in_op        = op_add;
        in_dest      = '0;
        in_src1      = '0;
        in_src2      = '0;
        in_imm       = '0;
        in_regwrite  = 1'b0;
        exp_push     = 1'b0;
        exp_line     = '0;
        exp_regwrite = 1'b0;
        exp_dest     = '0;
        exp_data     = '0;
        run_done     = 1'b0;
        load_stimulus(file_ok);
        if (!file_ok)
        begin
            $display("Stimulus file %s could not be opened", STIM_FILE);
            $display("*** TEST FAILED ***");
            $finish;
        end
        else
        begin
            timeout_limit = line_q.size() + RESET_CYCLES + 10;
            repeat (RESET_CYCLES) @(posedge clk);
            arst_n <= 1'b1;
            for (int i = 0; i < line_q.size(); i++)
            begin
                @(posedge clk);
                drive_line(i);
            end
            @(posedge clk);
            drive_idle();
            drain = 0;
            while ((pending != 0) && (drain < DRAIN_CYCLES))
            begin
                @(posedge clk);
                drain = drain + 1;
            end
            run_done <= 1'b1;  // Checker reports anything left over
            repeat (2) @(posedge clk);
            $display("Lines: %0d, write-backs checked: %0d, errors: %0d",
                     line_q.size(), check_count, error_count);
            if (error_count == 0)
                $display("*** TEST PASSED ***");
            else
                $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: pipe_fwd.f
rtl/pipe_pkg.sv
rtl/reg_file.sv
rtl/forwarding_control.sv
rtl/alu.sv
rtl/operand_read.sv
rtl/execute_stage.sv
rtl/pipe_core.sv
testbench/pipe_fwd_checker.sv
testbench/pipe_fwd_tb.sv

// File: testbench/pipe_fwd_stimulus.txt
// issue op dest src1 src2 imm regwrite expected_wb_data, all hex
// op: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt, 6 addi, 7 li
1 7 1 0 0 0012 1 0012
1 7 2 0 0 0034 1 0034
1 7 3 0 0 fff0 1 fff0
1 7 4 0 0 0005 1 0005
0 0 0 0 0 0000 0 0000
0 0 0 0 0 0000 0 0000
1 0 5 1 2 0000 1 0046
1 1 6 1 2 0000 1 ffde
1 2 7 2 3 0000 1 0030
1 3 5 1 4 0000 1 0017
1 4 6 2 3 0000 1 ffc4
1 5 7 3 1 0000 1 0001
1 6 5 4 0 0100 1 0105
1 0 6 1 2 0000 1 0046
1 1 7 6 1 0000 1 0034
1 0 1 2 7 0000 1 0068
1 7 2 0 0 0200 1 0200
1 3 3 4 0 0000 1 0005
1 0 4 2 1 0000 1 0268
1 7 5 0 0 1111 1 1111
1 7 5 0 0 2222 1 2222
1 6 6 5 0 0001 1 2223
1 7 7 0 0 0300 1 0300
1 7 1 0 0 0040 1 0040
1 1 2 7 1 0000 1 02c0
1 7 0 0 0 7777 1 7777
1 0 3 0 2 0000 1 02c0
0 7 4 0 0 5555 1 0000
1 0 5 4 0 0000 1 0268
1 3 4 0 0 0000 1 0000
1 4 6 1 1 0000 0 0000
1 6 7 6 0 0000 1 2223
0 0 0 0 0 0000 0 0000
1 3 1 6 0 0000 1 2223
0 0 0 0 0 0000 0 0000
